// File: rtl/rv_core_settings.svh
// RV32I core constants: datapath widths, reset PC, opcode, funct3 and ALU codes
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Datapath widths
`define RV_XLEN        32
`define RV_REG_AW      5
`define RV_ALU_OPW     4

`define RV_RESET_PC    32'h0000_0000

// Major opcodes, instr[6:0]
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111

// funct3 for OP and OP-IMM
`define RV_F3_ADD      3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

// funct3 for branches
`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001

// ALU operation codes
`define RV_ALU_ADD     4'd0
`define RV_ALU_SUB     4'd1
`define RV_ALU_AND     4'd2
`define RV_ALU_OR      4'd3
`define RV_ALU_XOR     4'd4
`define RV_ALU_SLT     4'd5
`define RV_ALU_SLTU    4'd6
`define RV_ALU_SLL     4'd7
`define RV_ALU_SRL     4'd8
`define RV_ALU_SRA     4'd9
`define RV_ALU_PASSB   4'd10

`endif

// File: rtl/rv_core_pkg.sv
// Width typedefs shared by every block of the RV32I pipeline core
`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

	// Data word, ALU operand or result
	typedef logic [`RV_XLEN-1:0] word_t;

	// Instruction address
	typedef logic [`RV_XLEN-1:0] pc_t;

	// Raw 32-bit instruction word
	typedef logic [31:0] instr_t;

	// Architectural register index
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;

	// ALU operation, see RV_ALU_* codes
	typedef logic [`RV_ALU_OPW-1:0] alu_op_t;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
// Integer register file: 31 writable registers, x0 hard zero, two read ports
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      i_arst_n,
	input  wire rv_core_pkg::reg_addr_t i_rs1,
	input  wire rv_core_pkg::reg_addr_t i_rs2,
	input  wire                      i_we,
	input  wire rv_core_pkg::reg_addr_t i_rd,
	input  wire rv_core_pkg::word_t  i_wdata,
	output rv_core_pkg::word_t       o_rs1_data,
	output rv_core_pkg::word_t       o_rs2_data
);

	rv_core_pkg::word_t regs [1:31];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_rd != '0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// Combinational reads
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	// Decode strips the write enable for rd = x0 two stages earlier
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		i_we |-> i_rd != '0
	) else $error("register file write enabled for x0");

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Fetch stage: PC register with branch/jump redirect and the IF/ID register
`default_nettype none

`include "rv_core_settings.svh"

module fetch_stage (
	input  wire                 clk,
	input  wire                 i_arst_n,
	input  wire                 i_redirect,
	input  wire rv_core_pkg::pc_t    i_redirect_pc,
	input  wire rv_core_pkg::instr_t i_imem_data,
	output rv_core_pkg::pc_t    o_imem_addr,
	output logic                o_if_valid,
	output rv_core_pkg::pc_t    o_if_pc,
	output rv_core_pkg::instr_t o_if_instr
);

	rv_core_pkg::pc_t pc;

	// Instruction memory is combinational, so the PC is the fetch address
	assign o_imem_addr = pc;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc         <= `RV_RESET_PC;
			o_if_valid <= 1'b0;
		end else if (i_redirect) begin
			pc         <= i_redirect_pc;
			// Drop the instruction fetched on the wrong path
			o_if_valid <= 1'b0;
		end else begin
			pc         <= pc + 32'd4;
			o_if_valid <= 1'b1;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		o_if_pc    <= pc;
		o_if_instr <= i_imem_data;
	end

	// Redirect targets come from execute and must keep word alignment
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		pc[1:0] == 2'b00
	) else $error("fetch PC lost word alignment");

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Decode stage: instruction decode, immediates, operand forwarding and ID/EX register
`default_nettype none

`include "rv_core_settings.svh"

module decode_stage (
	input  wire                         clk,
	input  wire                         i_arst_n,
	input  wire                         i_if_valid,
	input  wire rv_core_pkg::pc_t       i_if_pc,
	input  wire rv_core_pkg::instr_t    i_if_instr,
	input  wire                         i_redirect,
	input  wire                         i_exe_we,
	input  wire rv_core_pkg::reg_addr_t i_exe_rd,
	input  wire rv_core_pkg::word_t     i_exe_result,
	input  wire                         i_wb_valid,
	input  wire rv_core_pkg::reg_addr_t i_wb_rd,
	input  wire rv_core_pkg::word_t     i_wb_data,
	output logic                        o_ex_valid,
	output rv_core_pkg::pc_t            o_ex_pc,
	output rv_core_pkg::reg_addr_t      o_ex_rd,
	output logic                        o_ex_we,
	output rv_core_pkg::alu_op_t        o_ex_alu_op,
	output rv_core_pkg::word_t          o_ex_opa,
	output rv_core_pkg::word_t          o_ex_opb,
	output rv_core_pkg::word_t          o_ex_imm,
	output logic                        o_ex_is_branch,
	output logic                        o_ex_branch_ne,
	output logic                        o_ex_is_jal
);

	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic                   funct7_alt;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::reg_addr_t rs1;
	rv_core_pkg::reg_addr_t rs2;

	rv_core_pkg::word_t     imm_i;
	rv_core_pkg::word_t     imm_u;
	rv_core_pkg::word_t     imm_b;
	rv_core_pkg::word_t     imm_j;

	logic                   dec_we;
	logic                   dec_use_imm;
	logic                   dec_is_branch;
	logic                   dec_branch_ne;
	logic                   dec_is_jal;
	rv_core_pkg::alu_op_t   dec_alu_op;
	rv_core_pkg::word_t     dec_imm;

	rv_core_pkg::word_t     rf_rs1_data;
	rv_core_pkg::word_t     rf_rs2_data;
	rv_core_pkg::word_t     rs1_val;
	rv_core_pkg::word_t     rs2_val;

	assign opcode     = i_if_instr[6:0];
	assign rd         = i_if_instr[11:7];
	assign funct3     = i_if_instr[14:12];
	assign rs1        = i_if_instr[19:15];
	assign rs2        = i_if_instr[24:20];
	assign funct7_alt = i_if_instr[30];

	// Sign-extended immediate formats
	assign imm_i = {{20{i_if_instr[31]}}, i_if_instr[31:20]};
	assign imm_u = {i_if_instr[31:12], 12'b0};
	assign imm_b = {{19{i_if_instr[31]}}, i_if_instr[31], i_if_instr[7],
		i_if_instr[30:25], i_if_instr[11:8], 1'b0};
	assign imm_j = {{11{i_if_instr[31]}}, i_if_instr[31], i_if_instr[19:12],
		i_if_instr[20], i_if_instr[30:21], 1'b0};

	// funct3/funct7 to ALU op; SUB only exists in register form
	function automatic rv_core_pkg::alu_op_t alu_from_funct(
		input logic [2:0] f3,
		input logic       alt,
		input logic       allow_sub
	);
		rv_core_pkg::alu_op_t op;
		case (f3)
			`RV_F3_ADD:  op = (alt && allow_sub) ? `RV_ALU_SUB : `RV_ALU_ADD;
			`RV_F3_SLL:  op = `RV_ALU_SLL;
			`RV_F3_SLT:  op = `RV_ALU_SLT;
			`RV_F3_SLTU: op = `RV_ALU_SLTU;
			`RV_F3_XOR:  op = `RV_ALU_XOR;
			`RV_F3_SR:   op = alt ? `RV_ALU_SRA : `RV_ALU_SRL;
			`RV_F3_OR:   op = `RV_ALU_OR;
			default:     op = `RV_ALU_AND;
		endcase
		return op;
	endfunction

	// Anything not listed falls out as a no-op
	always_comb begin
		dec_we        = 1'b0;
		dec_use_imm   = 1'b0;
		dec_is_branch = 1'b0;
		dec_branch_ne = 1'b0;
		dec_is_jal    = 1'b0;
		dec_alu_op    = `RV_ALU_ADD;
		dec_imm       = imm_i;
		case (opcode)
			`RV_OPC_OP: begin
				dec_we     = 1'b1;
				dec_alu_op = alu_from_funct(funct3, funct7_alt, 1'b1);
			end
			`RV_OPC_OPIMM: begin
				dec_we      = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = alu_from_funct(funct3, funct7_alt, 1'b0);
			end
			`RV_OPC_LUI: begin
				dec_we      = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = `RV_ALU_PASSB;
				dec_imm     = imm_u;
			end
			`RV_OPC_BRANCH: begin
				// Only BEQ and BNE are implemented
				dec_is_branch = (funct3 == `RV_F3_BEQ) || (funct3 == `RV_F3_BNE);
				dec_branch_ne = (funct3 == `RV_F3_BNE);
				dec_imm       = imm_b;
			end
			`RV_OPC_JAL: begin
				dec_we     = 1'b1;
				dec_is_jal = 1'b1;
				dec_imm    = imm_j;
			end
			default: ;
		endcase
	end

	reg_file reg_file_inst (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.i_we       (i_wb_valid),
		.i_rd       (i_wb_rd),
		.i_wdata    (i_wb_data),
		.o_rs1_data (rf_rs1_data),
		.o_rs2_data (rf_rs2_data)
	);

	// Newest value wins: execute, then writeback, then register file
	always_comb begin
		if (rs1 == '0)
			rs1_val = '0;
		else if (i_exe_we && i_exe_rd == rs1)
			rs1_val = i_exe_result;
		else if (i_wb_valid && i_wb_rd == rs1)
			rs1_val = i_wb_data;
		else
			rs1_val = rf_rs1_data;

		if (rs2 == '0)
			rs2_val = '0;
		else if (i_exe_we && i_exe_rd == rs2)
			rs2_val = i_exe_result;
		else if (i_wb_valid && i_wb_rd == rs2)
			rs2_val = i_wb_data;
		else
			rs2_val = rf_rs2_data;
	end

	// ID/EX control
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ex_valid     <= 1'b0;
			o_ex_we        <= 1'b0;
			o_ex_is_branch <= 1'b0;
			o_ex_branch_ne <= 1'b0;
			o_ex_is_jal    <= 1'b0;
		end else begin
			// Slot in decode is on the wrong path when execute redirects
			o_ex_valid     <= i_if_valid && !i_redirect;
			o_ex_we        <= dec_we && (rd != '0);
			o_ex_is_branch <= dec_is_branch;
			o_ex_branch_ne <= dec_branch_ne;
			o_ex_is_jal    <= dec_is_jal;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		o_ex_pc     <= i_if_pc;
		o_ex_rd     <= rd;
		o_ex_alu_op <= dec_alu_op;
		o_ex_opa    <= rs1_val;
		o_ex_opb    <= dec_use_imm ? dec_imm : rs2_val;
		o_ex_imm    <= dec_imm;
	end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage with the ALU, BEQ/BNE/JAL resolution and the EX/WB register
`default_nettype none

`include "rv_core_settings.svh"

module execute_stage (
	input  wire                         clk,
	input  wire                         i_arst_n,
	input  wire                         i_ex_valid,
	input  wire rv_core_pkg::pc_t       i_ex_pc,
	input  wire rv_core_pkg::reg_addr_t i_ex_rd,
	input  wire                         i_ex_we,
	input  wire rv_core_pkg::alu_op_t   i_ex_alu_op,
	input  wire rv_core_pkg::word_t     i_ex_opa,
	input  wire rv_core_pkg::word_t     i_ex_opb,
	input  wire rv_core_pkg::word_t     i_ex_imm,
	input  wire                         i_ex_is_branch,
	input  wire                         i_ex_branch_ne,
	input  wire                         i_ex_is_jal,
	output logic                        o_redirect,
	output rv_core_pkg::pc_t            o_redirect_pc,
	output logic                        o_exe_we,
	output rv_core_pkg::reg_addr_t      o_exe_rd,
	output rv_core_pkg::word_t          o_exe_result,
	output logic                        o_wb_valid,
	output rv_core_pkg::reg_addr_t      o_wb_rd,
	output rv_core_pkg::word_t          o_wb_data
);

	rv_core_pkg::word_t alu_result;
	logic [4:0]         shamt;
	logic               operands_eq;
	logic               branch_taken;

	assign shamt = i_ex_opb[4:0];

	always_comb begin
		case (i_ex_alu_op)
			`RV_ALU_ADD:   alu_result = i_ex_opa + i_ex_opb;
			`RV_ALU_SUB:   alu_result = i_ex_opa - i_ex_opb;
			`RV_ALU_AND:   alu_result = i_ex_opa & i_ex_opb;
			`RV_ALU_OR:    alu_result = i_ex_opa | i_ex_opb;
			`RV_ALU_XOR:   alu_result = i_ex_opa ^ i_ex_opb;
			`RV_ALU_SLT:
				alu_result = {31'b0, $signed(i_ex_opa) < $signed(i_ex_opb)};
			`RV_ALU_SLTU:  alu_result = {31'b0, i_ex_opa < i_ex_opb};
			`RV_ALU_SLL:   alu_result = i_ex_opa << shamt;
			`RV_ALU_SRL:   alu_result = i_ex_opa >> shamt;
			`RV_ALU_SRA:   alu_result = $signed(i_ex_opa) >>> shamt;
			`RV_ALU_PASSB: alu_result = i_ex_opb;
			default:       alu_result = '0;
		endcase
	end

	// JAL writes the link address instead of the ALU value
	assign o_exe_result = i_ex_is_jal ? (i_ex_pc + 32'd4) : alu_result;
	assign o_exe_rd     = i_ex_rd;
	assign o_exe_we     = i_ex_valid && i_ex_we;

	// Branch operands are the raw register values
	assign operands_eq  = (i_ex_opa == i_ex_opb);
	assign branch_taken = i_ex_is_branch && (operands_eq != i_ex_branch_ne);

	assign o_redirect    = i_ex_valid && (branch_taken || i_ex_is_jal);
	assign o_redirect_pc = i_ex_pc + i_ex_imm;

	// Only writing instructions occupy EX/WB
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= o_exe_we;
		end
	end

	always_ff @(posedge clk) begin
		if (o_exe_we) begin
			o_wb_rd   <= i_ex_rd;
			o_wb_data <= o_exe_result;
		end
	end

	// Redirect squashes the decode slot and so never lasts two cycles
	a_redirect_pulse: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		o_redirect |=> !o_redirect
	) else $error("redirect held for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
// RV32I four-stage in-order core: fetch, decode, execute, writeback
`default_nettype none

module rv_core (
	input  wire                         clk,
	input  wire                         i_arst_n,
	input  wire rv_core_pkg::instr_t    i_imem_data,
	output rv_core_pkg::pc_t            o_imem_addr,
	output logic                        o_wb_valid,
	output rv_core_pkg::reg_addr_t      o_wb_rd,
	output rv_core_pkg::word_t          o_wb_data
);

	// Fetch to decode
	logic                   if_valid;
	rv_core_pkg::pc_t       if_pc;
	rv_core_pkg::instr_t    if_instr;

	// ID/EX
	logic                   ex_valid;
	rv_core_pkg::pc_t       ex_pc;
	rv_core_pkg::reg_addr_t ex_rd;
	logic                   ex_we;
	rv_core_pkg::alu_op_t   ex_alu_op;
	rv_core_pkg::word_t     ex_opa;
	rv_core_pkg::word_t     ex_opb;
	rv_core_pkg::word_t     ex_imm;
	logic                   ex_is_branch;
	logic                   ex_branch_ne;
	logic                   ex_is_jal;

	// Execute feedback
	logic                   redirect;
	rv_core_pkg::pc_t       redirect_pc;
	logic                   exe_we;
	rv_core_pkg::reg_addr_t exe_rd;
	rv_core_pkg::word_t     exe_result;

	fetch_stage fetch_stage_inst (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_redirect    (redirect),
		.i_redirect_pc (redirect_pc),
		.i_imem_data   (i_imem_data),
		.o_imem_addr   (o_imem_addr),
		.o_if_valid    (if_valid),
		.o_if_pc       (if_pc),
		.o_if_instr    (if_instr)
	);

	// Writeback register feeds both the register file and the core outputs
	decode_stage decode_stage_inst (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_if_valid     (if_valid),
		.i_if_pc        (if_pc),
		.i_if_instr     (if_instr),
		.i_redirect     (redirect),
		.i_exe_we       (exe_we),
		.i_exe_rd       (exe_rd),
		.i_exe_result   (exe_result),
		.i_wb_valid     (o_wb_valid),
		.i_wb_rd        (o_wb_rd),
		.i_wb_data      (o_wb_data),
		.o_ex_valid     (ex_valid),
		.o_ex_pc        (ex_pc),
		.o_ex_rd        (ex_rd),
		.o_ex_we        (ex_we),
		.o_ex_alu_op    (ex_alu_op),
		.o_ex_opa       (ex_opa),
		.o_ex_opb       (ex_opb),
		.o_ex_imm       (ex_imm),
		.o_ex_is_branch (ex_is_branch),
		.o_ex_branch_ne (ex_branch_ne),
		.o_ex_is_jal    (ex_is_jal)
	);

	execute_stage execute_stage_inst (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_ex_valid     (ex_valid),
		.i_ex_pc        (ex_pc),
		.i_ex_rd        (ex_rd),
		.i_ex_we        (ex_we),
		.i_ex_alu_op    (ex_alu_op),
		.i_ex_opa       (ex_opa),
		.i_ex_opb       (ex_opb),
		.i_ex_imm       (ex_imm),
		.i_ex_is_branch (ex_is_branch),
		.i_ex_branch_ne (ex_branch_ne),
		.i_ex_is_jal    (ex_is_jal),
		.o_redirect     (redirect),
		.o_redirect_pc  (redirect_pc),
		.o_exe_we       (exe_we),
		.o_exe_rd       (exe_rd),
		.o_exe_result   (exe_result),
		.o_wb_valid     (o_wb_valid),
		.o_wb_rd        (o_wb_rd),
		.o_wb_data      (o_wb_data)
	);

endmodule

`default_nettype wire

// File: verif/rv_core_tb.sv
// Testbench for the RV32I core: program ROM, in-order reference model and writeback checks
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int                  rom_words  = 128;
	localparam int                  max_writes = 128;
	localparam rv_core_pkg::instr_t nop_instr  = 32'h0000_0013;

	logic                   clk = 1'b0;
	logic                   i_arst_n;
	rv_core_pkg::instr_t    i_imem_data;
	rv_core_pkg::pc_t       o_imem_addr;
	logic                   o_wb_valid;
	rv_core_pkg::reg_addr_t o_wb_rd;
	rv_core_pkg::word_t     o_wb_data;

	// Program words and the behavior each one belongs to
	rv_core_pkg::instr_t rom [0:rom_words-1];
	string               rom_test [0:rom_words-1];
	int                  prog_len = 0;

	// Expected writeback beats in program order
	rv_core_pkg::reg_addr_t exp_rd [0:max_writes-1];
	rv_core_pkg::word_t     exp_data [0:max_writes-1];
	string                  exp_test [0:max_writes-1];
	int                     exp_count = 0;
	int                     exp_idx = 0;

	integer seed = 95292;
	int     cyc = 0;
	logic   reset_check = 1'b0;

	rv_core rv_core_inst (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_imem_data (i_imem_data),
		.o_imem_addr (o_imem_addr),
		.o_wb_valid  (o_wb_valid),
		.o_wb_rd     (o_wb_rd),
		.o_wb_data   (o_wb_data)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Instruction encoders
	function automatic rv_core_pkg::instr_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic rv_core_pkg::instr_t encode_i(input logic [2:0] f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OPIMM};
	endfunction

	function automatic rv_core_pkg::instr_t encode_shift(input logic alt, input logic [2:0] f3,
		input int rd, input int rs1, input int shamt);
		return {1'b0, alt, 5'b00000, shamt[4:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OPIMM};
	endfunction

	function automatic rv_core_pkg::instr_t encode_lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], `RV_OPC_LUI};
	endfunction

	function automatic rv_core_pkg::instr_t encode_branch(input logic [2:0] f3, input int rs1,
		input int rs2, input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OPC_BRANCH};
	endfunction

	function automatic rv_core_pkg::instr_t encode_jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	task automatic emit(input rv_core_pkg::instr_t w, input string test);
		rom[prog_len[6:0]]      = w;
		rom_test[prog_len[6:0]] = test;
		prog_len++;
	endtask

	task automatic build_program();
		integer r1;
		integer r2;
		integer r3;
		integer r4;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		r4 = $random(seed);
		emit(encode_i(`RV_F3_ADD, 1, 0, r1), "reset");
		emit(encode_i(`RV_F3_ADD, 2, 0, r2), "alu_imm");
		emit(encode_lui(3, r3), "lui");
		emit(encode_r(7'h00, `RV_F3_ADD, 4, 1, 2), "alu_reg");
		emit(encode_r(7'h20, `RV_F3_ADD, 5, 1, 2), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_AND, 6, 1, 3), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_OR, 7, 1, 3), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_XOR, 8, 2, 3), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_SLT, 9, 1, 2), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_SLTU, 10, 1, 2), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_SLL, 11, 3, 2), "alu_reg");
		emit(encode_r(7'h00, `RV_F3_SR, 12, 3, 2), "alu_reg");
		emit(encode_r(7'h20, `RV_F3_SR, 13, 3, 2), "alu_reg");
		emit(encode_i(`RV_F3_XOR, 14, 1, r4), "alu_imm");
		emit(encode_i(`RV_F3_OR, 15, 2, 'h0f0), "alu_imm");
		emit(encode_i(`RV_F3_AND, 16, 3, -1), "alu_imm");
		emit(encode_i(`RV_F3_SLT, 17, 1, r4), "alu_imm");
		emit(encode_i(`RV_F3_SLTU, 18, 1, -1), "alu_imm");
		emit(encode_shift(1'b0, `RV_F3_SLL, 19, 1, 5), "alu_imm");
		emit(encode_shift(1'b0, `RV_F3_SR, 20, 3, 9), "alu_imm");
		emit(encode_shift(1'b1, `RV_F3_SR, 21, 3, 9), "alu_imm");
		emit(encode_i(`RV_F3_ADD, 22, 3, -2048), "alu_imm");
		emit(encode_lui(23, -1), "lui");
		// Chains at distance 1, 2 and 3
		emit(encode_i(`RV_F3_ADD, 5, 0, 7), "forwarding");
		emit(encode_i(`RV_F3_ADD, 5, 5, 3), "forwarding");
		emit(encode_r(7'h00, `RV_F3_ADD, 6, 5, 5), "forwarding");
		emit(encode_i(`RV_F3_ADD, 7, 0, 11), "forwarding");
		emit(encode_i(`RV_F3_ADD, 8, 0, 1), "forwarding");
		emit(encode_r(7'h00, `RV_F3_ADD, 9, 7, 6), "forwarding");
		emit(encode_r(7'h20, `RV_F3_ADD, 10, 9, 7), "forwarding");
		// Taken and not-taken BEQ/BNE
		emit(encode_i(`RV_F3_ADD, 14, 0, 5), "branch");
		emit(encode_i(`RV_F3_ADD, 15, 0, 5), "branch");
		emit(encode_branch(`RV_F3_BEQ, 14, 15, 12), "branch");
		emit(encode_i(`RV_F3_ADD, 16, 0, 99), "branch");
		emit(encode_i(`RV_F3_ADD, 17, 0, 98), "branch");
		emit(encode_i(`RV_F3_ADD, 18, 0, 1), "branch");
		emit(encode_branch(`RV_F3_BNE, 14, 15, 12), "branch");
		emit(encode_i(`RV_F3_ADD, 16, 0, 2), "branch");
		emit(encode_branch(`RV_F3_BNE, 14, 0, 12), "branch");
		emit(encode_i(`RV_F3_ADD, 19, 0, 77), "branch");
		emit(encode_i(`RV_F3_ADD, 20, 0, 76), "branch");
		emit(encode_branch(`RV_F3_BEQ, 14, 18, 12), "branch");
		emit(encode_i(`RV_F3_ADD, 20, 0, 3), "branch");
		emit(encode_jal(23, 12), "jal");
		emit(encode_i(`RV_F3_ADD, 24, 0, 1), "jal");
		emit(encode_i(`RV_F3_ADD, 25, 0, 1), "jal");
		emit(encode_i(`RV_F3_ADD, 26, 23, 4), "jal");
		emit(encode_jal(0, 8), "jal");
		emit(encode_i(`RV_F3_ADD, 27, 0, 1), "jal");
		// Writes to x0 then reads of it
		emit(encode_i(`RV_F3_ADD, 0, 1, 5), "x0");
		emit(encode_r(7'h00, `RV_F3_ADD, 28, 0, 0), "x0");
		emit(encode_lui(0, 'h12345), "x0");
		emit(encode_i(`RV_F3_ADD, 29, 0, -1), "x0");
		emit(encode_r(7'h00, `RV_F3_SLTU, 30, 0, 29), "x0");
		emit(32'h0000_007f, "unknown_opcode");
		emit(encode_i(`RV_F3_ADD, 31, 30, 1), "unknown_opcode");
	endtask

	// ISA result for OP and OP-IMM, funct3 values from the RV32I spec
	function automatic rv_core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input logic is_reg, input rv_core_pkg::word_t a, input rv_core_pkg::word_t b);
		rv_core_pkg::word_t r;
		case (f3)
			3'b000: r = (is_reg && alt) ? a - b : a + b;
			3'b001: r = a << b[4:0];
			3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: r = (a < b) ? 32'd1 : 32'd0;
			3'b100: r = a ^ b;
			3'b101: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// Architectural run of the program, squashed slots never execute
	task automatic run_model();
		rv_core_pkg::word_t  regs [0:31];
		rv_core_pkg::word_t  a;
		rv_core_pkg::word_t  b;
		rv_core_pkg::word_t  res;
		rv_core_pkg::pc_t    pc;
		rv_core_pkg::pc_t    next_pc;
		rv_core_pkg::instr_t w;
		logic                wr;
		int                  steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc    = `RV_RESET_PC;
		steps = 0;
		while (pc < 32'(prog_len * 4) && steps < 4 * rom_words) begin
			w       = rom[pc[8:2]];
			a       = regs[w[19:15]];
			b       = regs[w[24:20]];
			wr      = 1'b0;
			res     = '0;
			next_pc = pc + 32'd4;
			case (w[6:0])
				`RV_OPC_OP: begin
					wr  = 1'b1;
					res = alu_ref(w[14:12], w[30], 1'b1, a, b);
				end
				`RV_OPC_OPIMM: begin
					wr  = 1'b1;
					res = alu_ref(w[14:12], w[30], 1'b0, a, {{20{w[31]}}, w[31:20]});
				end
				`RV_OPC_LUI: begin
					wr  = 1'b1;
					res = {w[31:12], 12'h000};
				end
				`RV_OPC_BRANCH: begin
					if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b))
						next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
				`RV_OPC_JAL: begin
					wr      = 1'b1;
					res     = pc + 32'd4;
					next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				default: ;
			endcase
			if (wr && w[11:7] != 5'd0) begin
				regs[w[11:7]]            = res;
				exp_rd[exp_count[6:0]]   = w[11:7];
				exp_data[exp_count[6:0]] = res;
				exp_test[exp_count[6:0]] = rom_test[pc[8:2]];
				exp_count++;
			end
			pc = next_pc;
			steps++;
		end
	endtask

	function automatic rv_core_pkg::instr_t fetch_word(input rv_core_pkg::pc_t addr);
		if (addr < 32'(prog_len * 4))
			return rom[addr[8:2]];
		else
			return nop_instr;
	endfunction

	// Combinational instruction memory, updated just after each edge
	always @(posedge clk) begin
		#1;
		i_imem_data = fetch_word(o_imem_addr);
	end

	always @(posedge clk) begin
		reset_check <= !i_arst_n;
		if (i_arst_n) begin
			cyc <= cyc + 1;
			if (o_wb_valid)
				exp_idx <= exp_idx + 1;
		end
	end

	// Idle at the reset PC during reset and in the first fetch cycle
	a_reset_state: assert property (@(negedge clk)
		reset_check |-> (!o_wb_valid && o_imem_addr == `RV_RESET_PC))
		else abort_run($sformatf("[ERROR] reset: expected wb_valid=0 pc=%h, actual wb_valid=%b pc=%h",
			`RV_RESET_PC, o_wb_valid, o_imem_addr));

	// First instruction writes back three cycles after its fetch
	a_first_write: assert property (@(negedge clk) disable iff (!i_arst_n)
		(cyc <= 3) |-> (o_wb_valid == (cyc == 3)))
		else abort_run($sformatf("[ERROR] reset: expected wb_valid=%b in cycle %0d, actual %b",
			cyc == 3, cyc, o_wb_valid));

	a_no_x0_beat: assert property (@(negedge clk) disable iff (!i_arst_n)
		o_wb_valid |-> o_wb_rd != 5'd0)
		else abort_run("a writeback beat targeted register x0");

	a_no_extra_write: assert property (@(negedge clk) disable iff (!i_arst_n)
		o_wb_valid |-> exp_idx < exp_count)
		else abort_run($sformatf("unexpected write to x%0d after all %0d expected writes",
			o_wb_rd, exp_count));

	a_wb_match: assert property (@(negedge clk) disable iff (!i_arst_n)
		(o_wb_valid && exp_idx < exp_count) |->
			(o_wb_rd == exp_rd[exp_idx[6:0]] && o_wb_data == exp_data[exp_idx[6:0]]))
		else abort_run($sformatf("[ERROR] %s: expected x%0d = %h, actual x%0d = %h",
			exp_test[exp_idx[6:0]], exp_rd[exp_idx[6:0]], exp_data[exp_idx[6:0]],
			o_wb_rd, o_wb_data));

	initial begin
		i_arst_n    = 1'b0;
		i_imem_data = nop_instr;
		build_program();
		run_model();
		repeat (16) @(posedge clk);
		#1 i_arst_n = 1'b1;
		// Run until fetch leaves the program, then let the pipeline drain
		while (o_imem_addr < 32'(prog_len * 4)) begin
			@(posedge clk);
			#1;
		end
		repeat (6) @(posedge clk);
		if (exp_idx != exp_count) begin
			abort_run($sformatf("only %0d of %0d expected writes were seen", exp_idx, exp_count));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

	initial begin
		wait (i_arst_n === 1'b1);
		#((prog_len + 40) * 10);
		abort_run("watchdog expired before the program finished writing back");
	end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
verif/rv_core_tb.sv

// File: Makefile
TOP := rv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f rv_core.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
